// File: sources.f
+incdir+include
source/phase_types_pkg.sv
source/phase_ctrl_pkg.sv
source/vibrato.sv
source/freq_multiplier.sv
source/phase_inc_calc.sv
source/phase_inc_top.sv
testbench/phase_inc_props.sv
testbench/phase_inc_tb.sv

// File: Makefile
# Verilator build and run of the phase increment testbench
# Override any variable on the command line, e.g. make run LOG=run2.log

VERILATOR ?= verilator
TOP       ?= phase_inc_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
PASS_MSG  ?= Simulation passed

EXE     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard source/*.sv testbench/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the exit status
run: compile
	./$(EXE) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Run did not pass, see $(LOG)"; exit 1; }
	@echo "Run passed, log in $(LOG)"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/phase_inc_tb.sv
/* Random requests against a model of the vibrato, multiplier table and scaling.
   sample_clk_en only pulses while req and ack are low, so each request sees a fixed LFO */
`timescale 1ns/100ps
`include "phase_consts.svh"

module phase_inc_tb
    import phase_types_pkg::*;
();

    localparam int N_CODES    = 16;
    localparam int VIB_STEPS  = 16;   // Pulse bursts in the vibrato sweep
    localparam int N_HOLD     = 10;
    localparam int N_RANDOM   = 200;
    localparam int N_TXN      = 1 + N_CODES + 2 * VIB_STEPS + N_HOLD + N_RANDOM;
    localparam int TXN_CYCLES = 14;   // Drive, latency 3, hold up to 8, release
    localparam int PULSE_CYCLES = VIB_STEPS * 1024 + N_RANDOM * 16;
    localparam int CYCLE_LIMIT  = N_TXN * TXN_CYCLES + PULSE_CYCLES + 500;
    localparam int ACK_WAIT_LIMIT = 16;

    logic     clk;
    logic     rst_n;
    logic     req;
    op_freq_t op_drv;
    logic     dvb;
    logic     sample_clk_en;
    logic     ack;
    logic [`PHASE_INC_WIDTH-1:0] phase_inc;

    int seed;
    int lfo_model;      // Pulses issued, mod 8192
    int errors;
    int checks;
    int test_err_base;
    int test_chk_base;
    int cycle_count;

    phase_inc_top UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .req           (req),
        .op            (op_drv),
        .dvb           (dvb),
        .sample_clk_en (sample_clk_en),
        .ack           (ack),
        .phase_inc     (phase_inc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns
    end

    // Hang guard
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run still going after %0d cycles", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // Doubled multiplier, x0.5 for code 0, then codes 10..15 pair up
    function automatic int mult_factor_of(input int code);
        if (code == 0) return 1;
        else if (code < 10) return 2 * code;
        else if (code < 12) return 20;
        else if (code < 14) return 24;
        else return 30;
    endfunction

    function automatic int vib_deviation(input int fnum, input int lfo, input bit deep);
        int dev;
        dev = fnum / 128;                          // Top 3 bits
        if (((lfo / 1024) % 4) == 3) dev = dev / 2;
        if (!deep) dev = dev / 2;
        if (lfo >= 4096) dev = 1023 - dev;         // Ones complement, 10 bits
        return dev;
    endfunction

    function automatic int model_phase_inc(input op_freq_t o, input int lfo, input bit deep);
        int eff;
        eff = int'(o.fnum);
        if (o.vib_en) eff = (eff + vib_deviation(eff, lfo, deep)) % 1024;
        return (eff * (1 << o.block) * mult_factor_of(int'(o.mult))) / 2;
    endfunction

    function automatic op_freq_t random_op(input bit vib);
        op_freq_t o;
        logic [31:0] r;
        r = $random(seed);
        o.fnum   = r[`FNUM_WIDTH-1:0];
        o.block  = r[12:10];
        o.mult   = r[16:13];
        o.vib_en = vib;
        return o;
    endfunction

    task automatic report_mismatch(input string name, input int want, input int got);
        $display("ERR %0t %s expected %0d got %0d", $time, name, want, got);
        errors = errors + 1;
    endtask

    task automatic issue_pulses(input int n);
        repeat (n) begin
            @(negedge clk);
            sample_clk_en = 1'b1;
            lfo_model = (lfo_model + 1) % 8192;
        end
        @(negedge clk);
        sample_clk_en = 1'b0;
    endtask

    // One four-phase transaction, req held for hold extra cycles after ack
    task automatic run_request(input op_freq_t o, input bit deep, input int hold);
        int want;
        int waited;
        logic [`PHASE_INC_WIDTH-1:0] held;
        want = model_phase_inc(o, lfo_model, deep);
        @(negedge clk);
        op_drv = o;
        dvb    = deep;
        req    = 1'b1;
        waited = 0;
        while (ack !== 1'b1 && waited < ACK_WAIT_LIMIT) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (ack !== 1'b1) begin
            $display("No ack within %0d cycles of the request at %0t", ACK_WAIT_LIMIT, $time);
            errors = errors + 1;
            req = 1'b0;
            return;
        end
        checks = checks + 2;
        // First negedge follows the capture edge
        assert (waited - 1 == 3) else report_mismatch("ack latency", 3, waited - 1);
        assert (int'(phase_inc) == want) else report_mismatch("phase_inc", want, int'(phase_inc));
        held = phase_inc;
        repeat (hold) begin
            @(negedge clk);
            checks = checks + 2;
            assert (ack === 1'b1) else report_mismatch("ack", 1, int'(ack));
            assert (phase_inc === held)
                else report_mismatch("phase_inc", int'(held), int'(phase_inc));
        end
        req = 1'b0;
        @(negedge clk);                           // ack drops on the edge after req
        checks = checks + 1;
        assert (ack === 1'b0) else report_mismatch("ack", 0, int'(ack));
    endtask

    task automatic finish_test(input int num, input string title);
        $display("Test %0d %s: %0d checks, %0d errors", num, title,
                 checks - test_chk_base, errors - test_err_base);
        test_chk_base = checks;
        test_err_base = errors;
    endtask

    initial begin
        op_freq_t o;
        logic [31:0] r;
        seed = 39385;
        rst_n = 1'b0;
        req = 1'b0;
        op_drv = '0;
        dvb = 1'b0;
        sample_clk_en = 1'b0;
        lfo_model = 0;
        errors = 0;
        checks = 0;
        test_err_base = 0;
        test_chk_base = 0;
        cycle_count = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // 1: reset values, then one plain request
        checks = checks + 2;
        assert (ack === 1'b0) else report_mismatch("ack", 0, int'(ack));
        assert (phase_inc === '0) else report_mismatch("phase_inc", 0, int'(phase_inc));
        r = $random(seed);
        run_request(random_op(1'b0), r[0], 0);
        finish_test(1, "reset and latency");

        // 2: every multiplier code
        for (int code = 0; code < N_CODES; code++) begin
            o = random_op(1'b0);
            o.mult = code[3:0];
            run_request(o, 1'b0, 0);
        end
        finish_test(2, "multiplier codes");

        // 3: bursts shorter than one octant, so no LFO octant is skipped
        for (int step = 0; step < VIB_STEPS; step++) begin
            r = $random(seed);
            issue_pulses(512 + r % 512);
            o = random_op(1'b1);
            run_request(o, 1'b0, 0);
            run_request(o, 1'b1, 0);
        end
        finish_test(3, "vibrato sweep");

        // 4: back-pressure
        for (int i = 0; i < N_HOLD; i++) begin
            r = $random(seed);
            run_request(random_op(r[1]), r[0], r % 9);
        end
        finish_test(4, "back-pressure");

        // 5: random traffic with LFO gaps
        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            issue_pulses(r % 16);
            run_request(random_op(r[5]), r[4], (r >> 8) % 9);
        end
        finish_test(5, "random transactions");

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: testbench/phase_inc_props.sv
/* Handshake properties, bound into phase_inc_calc.
   Assumes the requester never raises req while ack is high */
`timescale 1ns/100ps
`include "phase_consts.svh"

module phase_inc_props (
    input logic clk,
    input logic rst_n,
    input logic req,
    input logic ack,
    input logic [`PHASE_INC_WIDTH-1:0] phase_inc
);

    // Synchronous reset clears ack on the next edge
    ack_low_after_reset: assert property (@(posedge clk) !rst_n |=> !ack)
        else $error("ack high after a reset edge");

    // Rising ack must answer a request
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose without req");

    ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && req) |=> ack)
        else $error("ack dropped while req still high");

    // Result frozen for the whole ack phase
    phase_inc_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && $past(ack)) |-> $stable(phase_inc))
        else $error("phase_inc changed while ack high");

endmodule

bind phase_inc_calc phase_inc_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .ack       (ack),
    .phase_inc (phase_inc)
);

// File: source/phase_inc_top.sv
/* Phase increment front end of one FM operator, one request at a time.
   sample_clk_en should only pulse while no request is in flight */
`timescale 1ns/100ps
`include "phase_consts.svh"

module phase_inc_top
    import phase_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req,
    input  op_freq_t op,
    input  logic     dvb,            // Global deep vibrato mode
    input  logic     sample_clk_en,
    output logic     ack,
    output logic [`PHASE_INC_WIDTH-1:0] phase_inc
);

    op_freq_t  cap_op;   // Captured request
    fnum_t     vib_dev;
    mult_res_t mres;

    vibrato u_vibrato (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_clk_en (sample_clk_en),
        .dvb           (dvb),
        .fnum          (cap_op.fnum),
        .vib_dev       (vib_dev)
    );

    freq_multiplier u_freq_multiplier (
        .clk   (clk),
        .rst_n (rst_n),
        .mult  (cap_op.mult),
        .block (cap_op.block),
        .res   (mres)
    );

    phase_inc_calc u_phase_inc_calc (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .op        (op),
        .cap_op    (cap_op),
        .vib_dev   (vib_dev),
        .mres      (mres),
        .ack       (ack),
        .phase_inc (phase_inc)
    );

endmodule

// File: source/phase_inc_calc.sv
/* Four-phase slave: ack rises 3 edges after the capture edge and falls on the
   first edge req is seen low. Requester must not raise req while ack is high */
`timescale 1ns/100ps
`include "phase_consts.svh"

module phase_inc_calc
    import phase_types_pkg::*;
    import phase_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req,
    input  op_freq_t  op,
    output op_freq_t  cap_op,     // Feeds vibrato and freq_multiplier
    input  fnum_t     vib_dev,
    input  mult_res_t mres,
    output logic      ack,
    output logic [`PHASE_INC_WIDTH-1:0] phase_inc  // Held while ack is high
);

    localparam logic [1:0] LAST_WAIT = 2'd2;  // Wait E1, E2, result at E3

    hs_state_t state;
    logic [1:0] wait_cnt;
    fnum_t eff_fnum;
    logic [`PHASE_INC_WIDTH:0] scaled;   // Extra lsb dropped by the final halving
    logic [`PHASE_INC_WIDTH:0] product;

    // Combination, only sampled at E3 when both pipelines are valid
    always_comb begin
        eff_fnum = cap_op.vib_en ? cap_op.fnum + vib_dev : cap_op.fnum;  // Mod 1024
        scaled   = {{(`PHASE_INC_WIDTH + 1 - `FNUM_WIDTH){1'b0}}, eff_fnum} << mres.shift;
        product  = scaled * {{(`PHASE_INC_WIDTH + 1 - `FACTOR_WIDTH){1'b0}}, mres.factor};
    end

    // Handshake FSM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= HS_IDLE;
            wait_cnt  <= '0;
            ack       <= 1'b0;
            phase_inc <= '0;
        end else begin
            case (state)
                HS_IDLE: begin
                    if (req) begin  // E0, capture below
                        state    <= HS_WAIT;
                        wait_cnt <= '0;
                    end
                end
                HS_WAIT: begin
                    if (wait_cnt == LAST_WAIT) begin
                        phase_inc <= product[`PHASE_INC_WIDTH:1];  // Undo doubled factor
                        ack       <= 1'b1;
                        state     <= HS_ACK;
                    end else begin
                        wait_cnt <= wait_cnt + 2'd1;
                    end
                end
                HS_ACK: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= HS_IDLE;
                    end
                end
                default: state <= HS_IDLE;
            endcase
        end
    end

    // Settings held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == HS_IDLE && req) begin
            cap_op <= op;
        end
    end

endmodule

// File: source/freq_multiplier.sv
/* Factor is returned doubled, so code 0 (x0.5) reads as 1.
   Result is registered, valid one edge after mult and block */
`timescale 1ns/100ps

module freq_multiplier
    import phase_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  mult_t     mult,
    input  block_t    block,
    output mult_res_t res
);

    factor_t factor;

    // Doubled multiplier table
    always_comb begin
        case (mult)
            4'd0:    factor = 5'd1;   // x0.5
            4'd1:    factor = 5'd2;
            4'd2:    factor = 5'd4;
            4'd3:    factor = 5'd6;
            4'd4:    factor = 5'd8;
            4'd5:    factor = 5'd10;
            4'd6:    factor = 5'd12;
            4'd7:    factor = 5'd14;
            4'd8:    factor = 5'd16;
            4'd9:    factor = 5'd18;
            4'd10:   factor = 5'd20;  // 10 and 11 both x10
            4'd11:   factor = 5'd20;
            4'd12:   factor = 5'd24;  // 12 and 13 both x12
            4'd13:   factor = 5'd24;
            4'd14:   factor = 5'd30;  // 14 and 15 both x15
            default: factor = 5'd30;  // Code 15
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res <= '0;
        end else begin
            res.factor <= factor;
            res.shift  <= block;  // Octave passes straight through
        end
    end

endmodule

// File: source/vibrato.sv
/* fnum must stay stable for two cycles. The LFO value is assumed fixed
   while a request is in flight, sample_clk_en is not held off internally */
`timescale 1ns/100ps
`include "phase_consts.svh"

module vibrato
    import phase_types_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  sample_clk_en,  // One pulse per audio sample
    input  logic  dvb,            // Deep vibrato
    input  fnum_t fnum,
    output fnum_t vib_dev         // Valid two edges after fnum
);

    localparam logic [`LFO_WIDTH-1:0] LFO_STEP = 1;

    logic [`LFO_WIDTH-1:0] lfo;   // Wraps every 8192 samples
    fnum_t fnum_p1;
    logic  dvb_p1;
    fnum_t delta0;
    fnum_t delta1;
    fnum_t delta2;

    // LFO
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfo <= '0;
        end else if (sample_clk_en) begin
            lfo <= lfo + LFO_STEP;
        end
    end

    // Stage 1
    always_ff @(posedge clk) begin
        fnum_p1 <= fnum;
        dvb_p1  <= dvb;
    end

    always_comb begin
        delta0 = fnum_p1 >> 7;  // Top 3 bits of fnum
        // Quarter with bits 11:10 set gives the smaller swing
        delta1 = (lfo[`LFO_WIDTH-2 -: 2] == 2'b11) ? delta0 >> 1 : delta0;
        delta2 = dvb_p1 ? delta1 : delta1 >> 1;  // Shallow mode halves again
    end

    // Stage 2, upper half of the LFO swings negative
    always_ff @(posedge clk) begin
        vib_dev <= lfo[`LFO_WIDTH-1] ? ~delta2 : delta2;  // Ones complement
    end

endmodule

// File: source/phase_ctrl_pkg.sv
/* Handshake states of the four-phase req/ack controller.
   One transaction in flight at a time */

package phase_ctrl_pkg;

    // Four-phase handshake
    //   HS_IDLE  ack low, waiting for req
    //   HS_WAIT  settings captured, pipeline filling
    //   HS_ACK   result held until req drops
    typedef enum logic [1:0] {
        HS_IDLE = 2'd0,
        HS_WAIT = 2'd1,
        HS_ACK  = 2'd2
    } hs_state_t;

endpackage

// File: source/phase_types_pkg.sv
/* Request word and multiplier result types, widths from the constants header.
   Field order is msb first: fnum, block, mult, vib_en */
`include "phase_consts.svh"

package phase_types_pkg;

    // Field types, shared by the three blocks
    typedef logic [`FNUM_WIDTH-1:0]   fnum_t;    // Also the vibrato deviation
    typedef logic [`BLOCK_WIDTH-1:0]  block_t;   // Octave
    typedef logic [`MULT_WIDTH-1:0]   mult_t;    // Table index, not an opcode
    typedef logic [`FACTOR_WIDTH-1:0] factor_t;  // Multiplier times two

    // One operator request, 18 bits
    typedef struct packed {
        fnum_t  fnum;
        block_t block;
        mult_t  mult;
        logic   vib_en;   // Add LFO deviation to fnum
    } op_freq_t;

    // Multiplier result, 8 bits
    typedef struct packed {
        factor_t factor;  // 1 means x0.5
        block_t  shift;   // Left shift of fnum, equal to block
    } mult_res_t;

endpackage

// File: include/phase_consts.svh
/* Widths of the phase increment path. PHASE_INC_WIDTH must hold
   fnum shifted by the largest block, times the largest factor, halved */
`ifndef PHASE_CONSTS_SVH
`define PHASE_CONSTS_SVH

// Operator settings
`define FNUM_WIDTH 10       // Frequency number
`define BLOCK_WIDTH 3       // Octave, also the left shift
`define MULT_WIDTH 4        // Multiplier table index

// Vibrato LFO, one step per sample
`define LFO_WIDTH 13

// Multiplier result, factor kept doubled so 0.5 stays integer
`define FACTOR_WIDTH 5

// (1023 << 7) * 30 / 2 fits here
`define PHASE_INC_WIDTH 21

`endif
